// File: verilog/cache_pkg.sv
/*
  Geometry of the direct-mapped cache: 64 lines of 256 bits, 32-bit byte addresses.
  Address split is tag[31:11], index[10:5], offset[4:0]; all accesses are aligned.
*/
`default_nettype none

package cache_pkg;

  // Requester side
  localparam int addr_w = 32;
  localparam int word_w = 64;

  // Line geometry
  localparam int line_w     = 256;
  localparam int line_words = line_w / word_w;
  localparam int num_lines  = 64;

  // Address fields
  localparam int off_w  = 5;
  localparam int idx_w  = 6;
  localparam int tag_w  = addr_w - idx_w - off_w;

  // Offset split into word select and byte-in-word
  localparam int word_bytes = word_w / 8;
  localparam int wsel_w     = 2;
  localparam int boff_w     = 3;

  // Size code on the requester port
  typedef enum logic [1:0] {
    size_64 = 2'd0,
    size_32 = 2'd1,
    size_16 = 2'd2
  } access_size_e;

  // Controller FSM
  typedef enum logic [2:0] {
    idle      = 3'd0,
    lookup    = 3'd1,
    respond   = 3'd2,
    fetch     = 3'd3,
    fill      = 3'd4,
    write_mem = 3'd5
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: verilog/mem_pkg.sv
/*
  Memory bus and register block definitions. Memory writes are one 64-bit word
  with byte strobes; reads return a full line.
*/
`default_nettype none

package mem_pkg;

  localparam int mem_addr_w = 32;
  localparam int mem_strb_w = 8;

  localparam int csr_addr_w = 2;
  localparam int csr_data_w = 32;

  // Register map of the configuration block
  typedef enum logic [csr_addr_w-1:0] {
    reg_ctrl   = 2'd0,
    reg_hits   = 2'd1,
    reg_misses = 2'd2,
    reg_status = 2'd3
  } csr_reg_e;

endpackage

`default_nettype wire

// File: verilog/cache_array.sv
/*
  Tag, valid and data storage. Lookup result appears the cycle after rd_en.
  inv_all wins over a fill on the same edge; word writes only touch a hitting line.
*/
`timescale 1ns/1ps
`default_nettype none

module cache_array (
  input  logic                          clk,
  input  logic                          rst,

  input  logic                          rd_en,
  input  logic [cache_pkg::addr_w-1:0]  rd_addr,
  output logic                          rd_hit,
  output logic [cache_pkg::line_w-1:0]  rd_line,

  input  logic                          fill_en,
  input  logic [cache_pkg::addr_w-1:0]  fill_addr,
  input  logic [cache_pkg::line_w-1:0]  fill_line,

  input  logic                          wr_en,
  input  logic [cache_pkg::addr_w-1:0]  wr_addr,
  input  logic [cache_pkg::word_w-1:0]  wr_data,
  input  logic [mem_pkg::mem_strb_w-1:0] wr_strb,

  input  logic                          inv_all
);
  import cache_pkg::*;
  import mem_pkg::*;

  logic [line_w-1:0]    data_mem [num_lines];
  logic [tag_w-1:0]     tag_mem  [num_lines];
  logic [num_lines-1:0] valid_q;

  logic [idx_w-1:0]  rd_idx;
  logic [idx_w-1:0]  fill_idx;
  logic [idx_w-1:0]  wr_idx;
  logic [tag_w-1:0]  rd_tag;
  logic [tag_w-1:0]  fill_tag;
  logic [tag_w-1:0]  wr_tag;
  logic [wsel_w-1:0] wr_wsel;
  logic              wr_hit;

  assign rd_idx   = rd_addr[off_w +: idx_w];
  assign rd_tag   = rd_addr[addr_w-1 -: tag_w];
  assign fill_idx = fill_addr[off_w +: idx_w];
  assign fill_tag = fill_addr[addr_w-1 -: tag_w];
  assign wr_idx   = wr_addr[off_w +: idx_w];
  assign wr_tag   = wr_addr[addr_w-1 -: tag_w];
  assign wr_wsel  = wr_addr[boff_w +: wsel_w];

  // Hit for the word write is decided here and nowhere else
  assign wr_hit = wr_en && valid_q[wr_idx] && (tag_mem[wr_idx] == wr_tag);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (inv_all) begin
      valid_q <= '0;
    end else if (fill_en) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  // Registered lookup
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_hit <= 1'b0;
    end else if (rd_en) begin
      rd_hit <= valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_line <= data_mem[rd_idx];
    end
  end

  // Line fill or byte merge into one word of a line
  always_ff @(posedge clk) begin
    if (fill_en) begin
      data_mem[fill_idx] <= fill_line;
      tag_mem[fill_idx]  <= fill_tag;
    end else if (wr_hit) begin
      for (int b = 0; b < mem_strb_w; b++) begin
        if (wr_strb[b]) begin
          data_mem[wr_idx][wr_wsel*word_w + b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
/*
  One request at a time. Read hit answers two cycles after acceptance; a miss or a
  bypassed read fetches the line. Writes always go through to memory, never allocate.
*/
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  logic                            clk,
  input  logic                            rst,

  input  logic                            req_valid,
  output logic                            req_ready,
  input  logic                            req_write,
  input  cache_pkg::access_size_e         req_size,
  input  logic [cache_pkg::addr_w-1:0]    req_addr,
  input  logic [cache_pkg::word_w-1:0]    req_wdata,
  output logic                            resp_valid,
  input  logic                            resp_ready,
  output logic [cache_pkg::word_w-1:0]    resp_rdata,

  output logic                            mem_req_valid,
  input  logic                            mem_req_ready,
  output logic                            mem_req_write,
  output logic [mem_pkg::mem_addr_w-1:0]  mem_req_addr,
  output logic [cache_pkg::word_w-1:0]    mem_req_wdata,
  output logic [mem_pkg::mem_strb_w-1:0]  mem_req_wstrb,
  input  logic                            mem_resp_valid,
  input  logic [cache_pkg::line_w-1:0]    mem_resp_line,

  output logic                            rd_en,
  output logic [cache_pkg::addr_w-1:0]    rd_addr,
  input  logic                            rd_hit,
  input  logic [cache_pkg::line_w-1:0]    rd_line,
  output logic                            fill_en,
  output logic [cache_pkg::addr_w-1:0]    fill_addr,
  output logic [cache_pkg::line_w-1:0]    fill_line,
  output logic                            wr_en,
  output logic [cache_pkg::addr_w-1:0]    wr_addr,
  output logic [cache_pkg::word_w-1:0]    wr_data,
  output logic [mem_pkg::mem_strb_w-1:0]  wr_strb,

  input  logic                            cache_en,
  output logic                            hit_pulse,
  output logic                            miss_pulse,
  output logic                            busy
);
  import cache_pkg::*;
  import mem_pkg::*;

  ctrl_state_e  state_q;
  logic         phase_q;

  // Latched request and fetched line
  logic               req_write_q;
  access_size_e       req_size_q;
  logic [addr_w-1:0]  req_addr_q;
  logic [word_w-1:0]  req_wdata_q;
  logic [line_w-1:0]  line_q;

  logic [word_w-1:0]     lane_data;
  logic [mem_strb_w-1:0] lane_strb;
  logic                  read_check;
  logic                  read_hit;

  // Pull the addressed quantity out of a line, zero-extended
  function automatic logic [word_w-1:0] extract(input logic [line_w-1:0] line,
                                                input logic [off_w-1:0]  off,
                                                input access_size_e      size);
    logic [word_w-1:0] word;
    logic [word_w-1:0] shifted;
    word    = line[off[boff_w +: wsel_w]*word_w +: word_w];
    shifted = word >> {off[boff_w-1:0], 3'b000};
    case (size)
      size_32: return {32'b0, shifted[31:0]};
      size_16: return {48'b0, shifted[15:0]};
      default: return shifted;
    endcase
  endfunction

  // Byte lanes of the write word
  always_comb begin
    case (req_size_q)
      size_32: lane_strb = 8'h0f;
      size_16: lane_strb = 8'h03;
      default: lane_strb = 8'hff;
    endcase
    lane_strb = lane_strb << req_addr_q[boff_w-1:0];
    lane_data = req_wdata_q << {req_addr_q[boff_w-1:0], 3'b000};
  end

  // Second lookup cycle of a read, array output is valid here
  assign read_check = (state_q == lookup) && phase_q && !req_write_q;
  assign read_hit   = rd_hit && cache_en;

  assign req_ready  = (state_q == idle);
  assign busy       = (state_q != idle);
  assign hit_pulse  = read_check && read_hit;
  assign miss_pulse = read_check && !read_hit;

  assign mem_req_write = req_write_q;
  assign mem_req_addr  = req_write_q ? {req_addr_q[addr_w-1:boff_w], {boff_w{1'b0}}}
                                     : {req_addr_q[addr_w-1:off_w], {off_w{1'b0}}};
  assign mem_req_wdata = lane_data;
  assign mem_req_wstrb = lane_strb;

  assign rd_en     = (state_q == lookup) && !phase_q && !req_write_q;
  assign rd_addr   = req_addr_q;
  assign fill_en   = (state_q == fill) && cache_en;
  assign fill_addr = req_addr_q;
  assign fill_line = line_q;
  assign wr_en     = (state_q == write_mem) && mem_req_valid && mem_req_ready;
  assign wr_addr   = req_addr_q;
  assign wr_data   = lane_data;
  assign wr_strb   = lane_strb;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= idle;
      phase_q       <= 1'b0;
      resp_valid    <= 1'b0;
      mem_req_valid <= 1'b0;
    end else begin
      case (state_q)
        idle: begin
          if (req_valid) begin
            state_q <= lookup;
          end
        end
        lookup: begin
          if (req_write_q) begin
            mem_req_valid <= 1'b1;
            state_q       <= write_mem;
          end else if (!phase_q) begin
            phase_q <= 1'b1;
          end else begin
            phase_q <= 1'b0;
            if (read_hit) begin
              resp_valid <= 1'b1;
              state_q    <= respond;
            end else begin
              mem_req_valid <= 1'b1;
              state_q       <= fetch;
            end
          end
        end
        fetch: begin
          if (mem_req_valid && mem_req_ready) begin
            mem_req_valid <= 1'b0;
          end
          if (mem_resp_valid) begin
            state_q <= fill;
          end
        end
        fill: begin
          resp_valid <= 1'b1;
          state_q    <= respond;
        end
        write_mem: begin
          if (mem_req_ready) begin
            mem_req_valid <= 1'b0;
            resp_valid    <= 1'b1;
            state_q       <= respond;
          end
        end
        respond: begin
          if (resp_ready) begin
            resp_valid <= 1'b0;
            state_q    <= idle;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  // Request fields, fetched line and response data
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      req_write_q <= req_write;
      req_size_q  <= req_size;
      req_addr_q  <= req_addr;
      req_wdata_q <= req_wdata;
    end
    if (state_q == fetch && mem_resp_valid) begin
      line_q <= mem_resp_line;
    end
    if (read_check && read_hit) begin
      resp_rdata <= extract(rd_line, req_addr_q[off_w-1:0], req_size_q);
    end else if (state_q == fill) begin
      resp_rdata <= extract(line_q, req_addr_q[off_w-1:0], req_size_q);
    end else if (wr_en) begin
      resp_rdata <= '0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/cache_csr.sv
/*
  Register block: enable, invalidate pulse, saturating hit/miss counters, status.
  Read data is combinational from the address. Any write to a counter clears it.
*/
`timescale 1ns/1ps
`default_nettype none

module cache_csr (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           csr_write,
  input  mem_pkg::csr_reg_e              csr_addr,
  input  logic [mem_pkg::csr_data_w-1:0] csr_wdata,
  output logic [mem_pkg::csr_data_w-1:0] csr_rdata,
  input  logic                           hit_pulse,
  input  logic                           miss_pulse,
  input  logic                           busy,
  output logic                           cache_en,
  output logic                           inv_all
);
  import mem_pkg::*;

  logic [csr_data_w-1:0] hits_q;
  logic [csr_data_w-1:0] misses_q;

  // Bit 1 of the control register is a strobe and never stored
  assign inv_all = csr_write && (csr_addr == reg_ctrl) && csr_wdata[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      cache_en <= 1'b1;
    end else if (csr_write && csr_addr == reg_ctrl) begin
      cache_en <= csr_wdata[0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hits_q   <= '0;
      misses_q <= '0;
    end else begin
      if (csr_write && csr_addr == reg_hits) begin
        hits_q <= '0;
      end else if (hit_pulse && hits_q != '1) begin
        hits_q <= hits_q + 1'b1;
      end
      if (csr_write && csr_addr == reg_misses) begin
        misses_q <= '0;
      end else if (miss_pulse && misses_q != '1) begin
        misses_q <= misses_q + 1'b1;
      end
    end
  end

  always_comb begin
    csr_rdata = '0;
    case (csr_addr)
      reg_ctrl:   csr_rdata[0] = cache_en;
      reg_hits:   csr_rdata    = hits_q;
      reg_misses: csr_rdata    = misses_q;
      reg_status: csr_rdata[0] = busy;
      default:    csr_rdata    = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/cache_top.sv
/*
  Write-through direct-mapped cache with its register block.
  The requester must never issue a misaligned access.
*/
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  logic                            clk,
  input  logic                            rst,

  input  logic                            req_valid,
  output logic                            req_ready,
  input  logic                            req_write,
  input  cache_pkg::access_size_e         req_size,
  input  logic [cache_pkg::addr_w-1:0]    req_addr,
  input  logic [cache_pkg::word_w-1:0]    req_wdata,
  output logic                            resp_valid,
  input  logic                            resp_ready,
  output logic [cache_pkg::word_w-1:0]    resp_rdata,

  output logic                            mem_req_valid,
  input  logic                            mem_req_ready,
  output logic                            mem_req_write,
  output logic [mem_pkg::mem_addr_w-1:0]  mem_req_addr,
  output logic [cache_pkg::word_w-1:0]    mem_req_wdata,
  output logic [mem_pkg::mem_strb_w-1:0]  mem_req_wstrb,
  input  logic                            mem_resp_valid,
  input  logic [cache_pkg::line_w-1:0]    mem_resp_line,

  input  logic                            csr_write,
  input  mem_pkg::csr_reg_e               csr_addr,
  input  logic [mem_pkg::csr_data_w-1:0]  csr_wdata,
  output logic [mem_pkg::csr_data_w-1:0]  csr_rdata
);
  import cache_pkg::*;
  import mem_pkg::*;

  // Controller to array
  logic                  rd_en;
  logic [addr_w-1:0]     rd_addr;
  logic                  rd_hit;
  logic [line_w-1:0]     rd_line;
  logic                  fill_en;
  logic [addr_w-1:0]     fill_addr;
  logic [line_w-1:0]     fill_line;
  logic                  wr_en;
  logic [addr_w-1:0]     wr_addr;
  logic [word_w-1:0]     wr_data;
  logic [mem_strb_w-1:0] wr_strb;

  // Register block links
  logic cache_en;
  logic inv_all;
  logic hit_pulse;
  logic miss_pulse;
  logic busy;

  cache_ctrl u_ctrl (
    .clk, .rst,
    .req_valid, .req_ready, .req_write, .req_size, .req_addr, .req_wdata,
    .resp_valid, .resp_ready, .resp_rdata,
    .mem_req_valid, .mem_req_ready, .mem_req_write, .mem_req_addr,
    .mem_req_wdata, .mem_req_wstrb, .mem_resp_valid, .mem_resp_line,
    .rd_en, .rd_addr, .rd_hit, .rd_line,
    .fill_en, .fill_addr, .fill_line,
    .wr_en, .wr_addr, .wr_data, .wr_strb,
    .cache_en, .hit_pulse, .miss_pulse, .busy
  );

  cache_array u_array (
    .clk, .rst,
    .rd_en, .rd_addr, .rd_hit, .rd_line,
    .fill_en, .fill_addr, .fill_line,
    .wr_en, .wr_addr, .wr_data, .wr_strb,
    .inv_all
  );

  cache_csr u_csr (
    .clk, .rst,
    .csr_write, .csr_addr, .csr_wdata, .csr_rdata,
    .hit_pulse, .miss_pulse, .busy,
    .cache_en, .inv_all
  );

endmodule

`default_nettype wire

// File: test/tb_mem_model.sv
/*
  Behavioral line memory for the cache testbench. Unwritten bytes return a fill
  pattern of their address. Only one read may be outstanding at a time.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            req_valid,
  output logic                            req_ready,
  input  logic                            req_write,
  input  logic [mem_pkg::mem_addr_w-1:0]  req_addr,
  input  logic [cache_pkg::word_w-1:0]    req_wdata,
  input  logic [mem_pkg::mem_strb_w-1:0]  req_wstrb,
  output logic                            resp_valid,
  output logic [cache_pkg::line_w-1:0]    resp_line
);
  import cache_pkg::*;
  import mem_pkg::*;

  // Sparse byte store, only written bytes live here
  logic [7:0]            bytes_q [logic [31:0]];
  logic                  pending;
  int                    wait_cnt;
  logic [mem_addr_w-1:0] pend_addr;

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ {a[12:8], a[15:13]} ^ a[23:16] ^ a[31:24] ^ 8'h3c;
  endfunction

  function automatic logic [7:0] read_byte(input logic [31:0] a);
    if (bytes_q.exists(a)) begin
      return bytes_q[a];
    end
    return fill_byte(a);
  endfunction

  // Byte i of the line sits in bits i*8 and up
  function automatic logic [line_w-1:0] read_line(input logic [31:0] base);
    logic [line_w-1:0] line;
    for (int i = 0; i < line_w / 8; i++) begin
      line[i*8 +: 8] = read_byte(base + i);
    end
    return line;
  endfunction

  // Outputs are quiet before the first reset edge
  initial begin
    req_ready  = 1'b0;
    resp_valid = 1'b0;
    resp_line  = '0;
  end

  always @(posedge clk) begin
    if (rst) begin
      req_ready  <= 1'b0;
      resp_valid <= 1'b0;
      pending    <= 1'b0;
      wait_cnt   <= 0;
    end else begin
      // Random back-pressure, roughly one cycle in four
      req_ready  <= ($urandom % 4) != 0;
      resp_valid <= 1'b0;
      if (req_valid && req_ready) begin
        if (req_write) begin
          for (int b = 0; b < mem_strb_w; b++) begin
            if (req_wstrb[b]) begin
              bytes_q[req_addr + b] = req_wdata[b*8 +: 8];
            end
          end
        end else begin
          pending   <= 1'b1;
          pend_addr <= req_addr;
          wait_cnt  <= 1 + ($urandom % 8);
        end
      end else if (pending) begin
        if (wait_cnt == 1) begin
          resp_valid <= 1'b1;
          resp_line  <= read_line(pend_addr);
          pending    <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_cache.sv
/*
  Cache testbench with a shadow of memory bytes and of the expected tags and valid bits.
  Assumes the memory model's fill pattern for bytes that were never written.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
  import cache_pkg::*;
  import mem_pkg::*;

  localparam int wait_limit = 400;

  logic                  clk;
  logic                  rst;
  logic                  req_valid;
  logic                  req_ready;
  logic                  req_write;
  access_size_e          req_size;
  logic [addr_w-1:0]     req_addr;
  logic [word_w-1:0]     req_wdata;
  logic                  resp_valid;
  logic                  resp_ready;
  logic [word_w-1:0]     resp_rdata;
  logic                  mem_req_valid;
  logic                  mem_req_ready;
  logic                  mem_req_write;
  logic [mem_addr_w-1:0] mem_req_addr;
  logic [word_w-1:0]     mem_req_wdata;
  logic [mem_strb_w-1:0] mem_req_wstrb;
  logic                  mem_resp_valid;
  logic [line_w-1:0]     mem_resp_line;
  logic                  csr_write;
  csr_reg_e              csr_addr;
  logic [csr_data_w-1:0] csr_wdata;
  logic [csr_data_w-1:0] csr_rdata;

  // Shadow memory and expected cache state
  logic [7:0]        shadow [logic [31:0]];
  logic              exp_valid [num_lines];
  logic [tag_w-1:0]  exp_tag [num_lines];
  logic              exp_en;
  int                exp_hits;
  int                exp_misses;
  int                reads_issued;
  logic [word_w-1:0] exp_q [$];

  int                err_count;
  int                tests_ok;
  int                tests_bad;
  int                test_num;
  int                test_err0;
  string             test_name;
  logic              resp_bp;
  logic              held;
  logic [word_w-1:0] held_data;
  logic [word_w-1:0] exp_data;

  cache_top u_dut (.*);

  tb_mem_model u_mem (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (mem_req_valid),
    .req_ready  (mem_req_ready),
    .req_write  (mem_req_write),
    .req_addr   (mem_req_addr),
    .req_wdata  (mem_req_wdata),
    .req_wstrb  (mem_req_wstrb),
    .resp_valid (mem_resp_valid),
    .resp_line  (mem_resp_line)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Same fill pattern as the memory model holds for unwritten bytes
  function automatic logic [7:0] default_byte(input logic [31:0] a);
    return a[7:0] ^ {a[12:8], a[15:13]} ^ a[23:16] ^ a[31:24] ^ 8'h3c;
  endfunction

  function automatic logic [7:0] shadow_byte(input logic [31:0] a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return default_byte(a);
  endfunction

  function automatic int size_bytes(input access_size_e size);
    case (size)
      size_32: return 4;
      size_16: return 2;
      default: return 8;
    endcase
  endfunction

  // Expected read value, zero-extended
  function automatic logic [word_w-1:0] ref_read(input logic [31:0] addr,
                                                 input access_size_e size);
    logic [word_w-1:0] val;
    val = '0;
    for (int i = 0; i < size_bytes(size); i++) begin
      val[i*8 +: 8] = shadow_byte(addr + i);
    end
    return val;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  // One request through to its response
  task automatic run_access(input logic wr, input access_size_e size,
                            input logic [31:0] addr, input logic [63:0] wdata);
    int               idx;
    logic [tag_w-1:0] tag;
    logic             hit;
    int               n;
    int               first_valid;
    idx = addr[off_w +: idx_w];
    tag = addr[addr_w-1 -: tag_w];
    hit = 1'b0;
    if (wr) begin
      exp_q.push_back('0);
      for (int i = 0; i < size_bytes(size); i++) begin
        shadow[addr + i] = wdata[i*8 +: 8];
      end
    end else begin
      exp_q.push_back(ref_read(addr, size));
      reads_issued++;
      hit = exp_en && exp_valid[idx] && (exp_tag[idx] == tag);
      if (hit) begin
        exp_hits++;
      end else begin
        exp_misses++;
        // Bypassed reads leave the array alone
        if (exp_en) begin
          exp_valid[idx] = 1'b1;
          exp_tag[idx]   = tag;
        end
      end
    end

    @(posedge clk);
    req_valid <= 1'b1;
    req_write <= wr;
    req_size  <= size;
    req_addr  <= addr;
    req_wdata <= wdata;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!req_ready && n < wait_limit);
    if (!req_ready) begin
      abort_on_timeout("req_ready");
    end
    req_valid <= 1'b0;

    n = 0;
    first_valid = 0;
    do begin
      @(posedge clk);
      n++;
      if (resp_valid && first_valid == 0) begin
        first_valid = n;
      end
      // Controller is never idle between acceptance and response transfer
      if (csr_addr == reg_status && csr_rdata !== 32'h1) begin
        $display("[ERROR] csr status while busy exp 0x1 got 0x%h", csr_rdata);
        err_count++;
      end
      if (resp_bp) begin
        resp_ready <= ($urandom % 3) == 0;
      end
    end while (!(resp_valid && resp_ready) && n < wait_limit);
    if (!(resp_valid && resp_ready)) begin
      abort_on_timeout("a response transfer");
    end
    resp_ready <= 1'b1;

    // Hit response is registered after edge T+2, so seen at edge T+3
    if (hit && first_valid != 3) begin
      $display("[ERROR] resp_valid latency exp 0x3 got 0x%0h at addr 0x%h", first_valid, addr);
      err_count++;
    end
  endtask

  task automatic csr_wr(input csr_reg_e r, input logic [31:0] d);
    @(posedge clk);
    csr_write <= 1'b1;
    csr_addr  <= r;
    csr_wdata <= d;
    @(posedge clk);
    csr_write <= 1'b0;
    case (r)
      reg_ctrl: begin
        exp_en = d[0];
        if (d[1]) begin
          for (int i = 0; i < num_lines; i++) begin
            exp_valid[i] = 1'b0;
          end
        end
      end
      reg_hits:   exp_hits = 0;
      reg_misses: exp_misses = 0;
      default: ;
    endcase
  endtask

  task automatic csr_rd(input csr_reg_e r, output logic [31:0] d);
    @(posedge clk);
    csr_addr <= r;
    @(posedge clk);
    d = csr_rdata;
  endtask

  task automatic check_counters();
    logic [31:0] v;
    csr_rd(reg_hits, v);
    if (v !== exp_hits) begin
      $display("[ERROR] csr hits exp 0x%h got 0x%h", exp_hits, v);
      err_count++;
    end
    csr_rd(reg_misses, v);
    if (v !== exp_misses) begin
      $display("[ERROR] csr misses exp 0x%h got 0x%h", exp_misses, v);
      err_count++;
    end
  endtask

  task automatic start_test(input string name);
    test_num++;
    test_name = name;
    test_err0 = err_count;
  endtask

  task automatic end_test();
    if (err_count == test_err0) begin
      tests_ok++;
      $display("Test %0d (%s): ok", test_num, test_name);
    end else begin
      tests_bad++;
      $display("Test %0d (%s): %0d errors", test_num, test_name, err_count - test_err0);
    end
  endtask

  // Checks every response transfer and holds data steady under back-pressure
  always @(posedge clk) begin
    if (rst) begin
      held = 1'b0;
    end else begin
      if (held && !resp_valid) begin
        $display("resp_valid dropped before the response was accepted");
        err_count++;
      end else if (held && resp_rdata !== held_data) begin
        $display("[ERROR] resp_rdata while stalled exp 0x%h got 0x%h", held_data, resp_rdata);
        err_count++;
      end
      if (resp_valid && resp_ready) begin
        if (exp_q.size() == 0) begin
          $display("A response arrived with no request outstanding");
          err_count++;
        end else begin
          exp_data = exp_q.pop_front();
          if (resp_rdata !== exp_data) begin
            $display("[ERROR] resp_rdata exp 0x%h got 0x%h", exp_data, resp_rdata);
            err_count++;
          end
        end
        held = 1'b0;
      end else begin
        held      = resp_valid;
        held_data = resp_rdata;
      end
    end
  end

  initial begin
    logic [31:0]  v;
    logic [31:0]  v2;
    logic [31:0]  a;
    logic [31:0]  boff;
    access_size_e sz;
    void'($urandom(32'hc1b7c311));
    rst        = 1'b1;
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_size   = size_64;
    req_addr   = '0;
    req_wdata  = '0;
    resp_ready = 1'b1;
    csr_write  = 1'b0;
    csr_addr   = reg_ctrl;
    csr_wdata  = '0;
    err_count  = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    test_num   = 0;
    exp_en     = 1'b1;
    exp_hits   = 0;
    exp_misses = 0;
    resp_bp    = 1'b0;
    reads_issued = 0;
    for (int i = 0; i < num_lines; i++) begin
      exp_valid[i] = 1'b0;
      exp_tag[i]   = '0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    start_test("miss then hit");
    run_access(1'b0, size_64, 32'h0000_1040, '0);
    run_access(1'b0, size_64, 32'h0000_1040, '0);
    check_counters();
    end_test();

    start_test("write-through with sizes");
    run_access(1'b1, size_16, 32'h0000_1048, 64'h0000_0000_0000_beef);
    run_access(1'b1, size_32, 32'h0000_105c, 64'h0000_0000_cafe_f00d);
    run_access(1'b1, size_64, 32'h0000_2000, 64'h0123_4567_89ab_cdef);
    // Same index as 0x1040 with another tag
    run_access(1'b1, size_16, 32'h0000_1842, 64'h0000_0000_0000_5a5a);
    run_access(1'b0, size_16, 32'h0000_1048, '0);
    run_access(1'b0, size_64, 32'h0000_1048, '0);
    run_access(1'b0, size_32, 32'h0000_105c, '0);
    run_access(1'b0, size_64, 32'h0000_1040, '0);
    run_access(1'b0, size_32, 32'h0000_2004, '0);
    run_access(1'b0, size_64, 32'h0000_2000, '0);
    run_access(1'b0, size_16, 32'h0000_1842, '0);
    check_counters();
    end_test();

    start_test("invalidate");
    run_access(1'b0, size_64, 32'h0000_2000, '0);
    csr_wr(reg_ctrl, 32'h3);
    csr_rd(reg_ctrl, v);
    if (v !== 32'h1) begin
      $display("[ERROR] csr ctrl exp 0x%h got 0x%h", 32'h1, v);
      err_count++;
    end
    run_access(1'b0, size_64, 32'h0000_2000, '0);
    run_access(1'b0, size_64, 32'h0000_1048, '0);
    run_access(1'b0, size_32, 32'h0000_105c, '0);
    check_counters();
    end_test();

    start_test("bypass");
    csr_wr(reg_ctrl, 32'h0);
    csr_rd(reg_status, v);
    if (v !== 32'h0) begin
      $display("[ERROR] csr status exp 0x%h got 0x%h", 32'h0, v);
      err_count++;
    end
    // Status stays selected, so these reads also see the busy bit
    repeat (3) run_access(1'b0, size_64, 32'h0000_3020, '0);
    csr_wr(reg_ctrl, 32'h1);
    run_access(1'b0, size_64, 32'h0000_3020, '0);
    check_counters();
    end_test();

    start_test("back-pressure");
    resp_bp = 1'b1;
    for (int i = 0; i < 12; i++) begin
      a = 32'h0000_4000 + (i % 3) * 32'h800 + (i % 4) * 8;
      run_access(1'((i % 3) == 1), size_64, a, {$urandom, $urandom});
    end
    resp_bp = 1'b0;
    check_counters();
    end_test();

    start_test("random mix");
    csr_wr(reg_hits, 32'h0);
    csr_wr(reg_misses, 32'hffff_ffff);
    reads_issued = 0;
    for (int i = 0; i < 200; i++) begin
      sz = access_size_e'($urandom % 3);
      case (sz)
        size_64: boff = 0;
        size_32: boff = ($urandom % 2) * 4;
        default: boff = ($urandom % 4) * 2;
      endcase
      // Four tags over two indices keep the lines conflicting
      a = 32'h0001_0000 | (($urandom % 4) << 11) | ((5 + $urandom % 2) << 5)
          | (($urandom % 4) << 3) | boff;
      run_access(1'($urandom % 2), sz, a, {$urandom, $urandom});
    end
    check_counters();
    csr_rd(reg_hits, v);
    csr_rd(reg_misses, v2);
    if (v + v2 !== reads_issued) begin
      $display("[ERROR] csr hits+misses exp 0x%h got 0x%h", reads_issued, v + v2);
      err_count++;
    end
    end_test();

    if (exp_q.size() != 0) begin
      $display("%0d requests never got a response", exp_q.size());
      err_count++;
    end
    $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
verilog/cache_pkg.sv
verilog/mem_pkg.sv
verilog/cache_array.sv
verilog/cache_ctrl.sv
verilog/cache_csr.sv
verilog/cache_top.sv
test/tb_mem_model.sv
test/tb_cache.sv
